/* list.f */
isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
alu_exe.sv
wb_stage.sv
mycpu_top.sv
tb_mycpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_mycpu with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mycpu -f list.f -o Vtb_mycpu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mycpu > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
if [ $status -ne 0 ] || ! grep -q "All checks passed" sim.log; then
    echo "RESULT: FAIL (simulation did not complete)"
    exit 1
fi
echo "RESULT: PASS"
exit 0

/* tb_mycpu.sv */
// ====================
// directed tests for mycpu_top against a reference register model
// instruction memory holds 1024 words starting at the boot address
// trace is checked every cycle, one entry per accepted word
// the run stops at the first mismatch
// ====================
`default_nettype none

module tb_mycpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] BOOT_PC   = 32'hBFC0_0000;

    typedef struct packed {
        logic [31:0] cyc;   // cycle in which the trace must show it
        logic [31:0] pc;
        logic [3:0]  wen;
        logic [4:0]  num;
        logic [31:0] data;
    } trace_t;

    logic        aclk;
    logic        rst;
    logic [31:0] inst_addr;
    logic [31:0] inst_data;
    logic        inst_valid;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] ref_regs [32];
    trace_t      exp_q [$];
    int          trace_head;        // next entry the monitor expects
    logic [31:0] cyc = '0;
    logic [31:0] model_pc;
    int          prog_end;
    int          issued;
    int          seed = 24871;
    logic        mon_on;

    mycpu_top uut (
        .aclk              (aclk),
        .rst               (rst),
        .inst_addr         (inst_addr),
        .inst_data         (inst_data),
        .inst_valid        (inst_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) cyc <= cyc + 32'd1;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail at %0t ns: %s = 0x%h, expected 0x%h",
                                $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] shift_word(input logic [5:0] fn, input logic [4:0] rd,
                                               input logic [4:0] rt, input logic [4:0] sa);
        return {isa_pkg::OP_SPECIAL, 5'd0, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // MIPS32 semantics written from the opcode tables
    task automatic model_exec(input logic [31:0] w, output logic wr, output logic [4:0] num,
                              output logic [31:0] data);
        logic [31:0] vs;
        logic [31:0] vt;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [4:0]  sa;
        logic        ok;
        vs   = ref_regs[w[25:21]];
        vt   = ref_regs[w[20:16]];
        sx   = {{16{w[15]}}, w[15:0]};
        zx   = {16'h0000, w[15:0]};
        sa   = w[10:6];
        ok   = 1'b1;
        num  = w[20:16];
        data = '0;
        if (w[31:26] == 6'h00) begin
            num = w[15:11];
            case (w[5:0])
                6'h00:   data = vt << sa;
                6'h02:   data = vt >> sa;
                6'h03:   data = $signed(vt) >>> sa;
                6'h21:   data = vs + vt;
                6'h23:   data = vs - vt;
                6'h24:   data = vs & vt;
                6'h25:   data = vs | vt;
                6'h26:   data = vs ^ vt;
                6'h27:   data = ~(vs | vt);
                6'h2A:   data = {31'd0, $signed(vs) < $signed(vt)};
                6'h2B:   data = {31'd0, vs < vt};
                default: ok = 1'b0;
            endcase
        end else begin
            case (w[31:26])
                6'h09:   data = vs + sx;
                6'h0A:   data = {31'd0, $signed(vs) < $signed(sx)};
                6'h0B:   data = {31'd0, vs < sx};   // compare against sign-extended imm
                6'h0C:   data = vs & zx;
                6'h0D:   data = vs | zx;
                6'h0E:   data = vs ^ zx;
                6'h0F:   data = {w[15:0], 16'h0000};
                default: ok = 1'b0;
            endcase
        end
        wr = ok && (num != 5'd0);
        if (wr) begin
            ref_regs[num] = data;
        end
    endtask

    task automatic put(input logic [31:0] w);
        if (prog_end >= MEM_WORDS) begin
            fail_stop("instruction memory is full");
        end else begin
            imem[10'(prog_end)] = w;
            prog_end++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge aclk);
        #1;
        check("inst_addr", inst_addr, model_pc);   // PC holds in a gap
        inst_valid = 1'b0;
        inst_data  = '0;
    endtask

    task automatic issue_one();
        logic [31:0] off;
        logic [31:0] w;
        logic        wr;
        logic [4:0]  num;
        logic [31:0] data;
        trace_t      e;
        @(posedge aclk);
        #1;
        check("inst_addr", inst_addr, model_pc);
        off = (inst_addr - BOOT_PC) >> 2;
        if (off >= 32'(MEM_WORDS)) begin
            fail_stop("fetch address lies outside the instruction memory");
        end else begin
            w          = imem[10'(off)];
            inst_data  = w;
            inst_valid = 1'b1;
            model_exec(w, wr, num, data);
            e.cyc  = cyc + 32'd3;   // accepted at next edge, traced two edges later
            e.pc   = model_pc;
            e.wen  = {4{wr}};
            e.num  = num;
            e.data = data;
            exp_q.push_back(e);
            model_pc = model_pc + 32'd4;
            issued++;
        end
    endtask

    task automatic drain_trace();
        int n;
        n = 0;
        while (trace_head < exp_q.size() && n < 20) begin
            idle_cycle();
            n++;
        end
        if (trace_head < exp_q.size()) begin
            fail_stop("timeout: trace entries still missing after 20 idle cycles");
        end
    endtask

    task automatic run_program(input logic gaps);
        int n;
        while (issued < prog_end) begin
            if (gaps && ($unsigned($random(seed)) % 32'd3) == 0) begin
                n = 1 + int'($unsigned($random(seed)) % 32'd4);
                repeat (n) idle_cycle();
            end
            issue_one();
        end
        drain_trace();
    endtask

    task automatic trace_compare();
        trace_t e;
        if (trace_head < exp_q.size() && exp_q[trace_head].cyc == cyc) begin
            e = exp_q[trace_head];
            trace_head++;
            check("debug_wb_pc", debug_wb_pc, e.pc);
            check("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'(e.wen));
            if (e.wen != 4'h0) begin
                check("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(e.num));
                check("debug_wb_rf_wdata", debug_wb_rf_wdata, e.data);
            end
        end else begin
            check("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0);  // bubble, no write
        end
    endtask

    // trace sampled mid-cycle, well after the register updates
    always begin
        @(posedge aclk);
        #2;
        if (mon_on) begin
            trace_compare();
        end
    end

    task automatic reset_values();
        check("inst_addr", inst_addr, BOOT_PC);
        check("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0);
    endtask

    task automatic independent_ops();
        put(i_word(isa_pkg::OP_LUI, 1, 0, 16'h8000));
        put(i_word(isa_pkg::OP_ORI, 1, 1, 16'h1234));
        put(i_word(isa_pkg::OP_ORI, 2, 0, 16'h0F0F));
        put(i_word(isa_pkg::OP_LUI, 3, 0, 16'hFFFF));
        put(i_word(isa_pkg::OP_ORI, 3, 3, 16'hFFF0));
        put(i_word(isa_pkg::OP_ORI, 4, 0, 16'h0005));
        put(r_word(isa_pkg::FN_ADDU, 10, 1, 2));
        put(r_word(isa_pkg::FN_SUBU, 11, 2, 1));
        put(r_word(isa_pkg::FN_AND, 12, 1, 3));
        put(r_word(isa_pkg::FN_OR, 13, 1, 2));
        put(r_word(isa_pkg::FN_XOR, 14, 3, 2));
        put(r_word(isa_pkg::FN_NOR, 15, 1, 2));
        put(r_word(isa_pkg::FN_SLT, 16, 1, 2));    // negative vs positive
        put(r_word(isa_pkg::FN_SLTU, 17, 1, 2));
        put(shift_word(isa_pkg::FN_SLL, 18, 1, 4));
        put(shift_word(isa_pkg::FN_SRL, 19, 1, 4));
        put(shift_word(isa_pkg::FN_SRA, 20, 1, 4));
        put(i_word(isa_pkg::OP_ADDIU, 21, 1, 16'hFFFF));
        put(i_word(isa_pkg::OP_ANDI, 22, 3, 16'hF0F0));
        put(i_word(isa_pkg::OP_ORI, 23, 2, 16'hF000));
        put(i_word(isa_pkg::OP_XORI, 24, 1, 16'hFFFF));
        put(i_word(isa_pkg::OP_SLTI, 25, 3, 16'hFFFF));
        put(i_word(isa_pkg::OP_SLTIU, 26, 3, 16'h8000));
        put(i_word(isa_pkg::OP_LUI, 27, 0, 16'hABCD));
        run_program(1'b0);
    endtask

    task automatic dependency_chains();
        put(r_word(isa_pkg::FN_ADDU, 5, 1, 2));
        put(r_word(isa_pkg::FN_ADDU, 6, 5, 5));    // distance 1
        put(r_word(isa_pkg::FN_SUBU, 7, 6, 5));    // distances 1 and 2
        put(i_word(isa_pkg::OP_ORI, 8, 0, 16'h0077));
        put(i_word(isa_pkg::OP_XORI, 9, 3, 16'h00FF));
        put(shift_word(isa_pkg::FN_SLL, 11, 4, 3));
        put(r_word(isa_pkg::FN_OR, 12, 8, 7));     // r8 at distance 3
        put(shift_word(isa_pkg::FN_SRA, 13, 12, 2));
        put(i_word(isa_pkg::OP_ADDIU, 13, 13, 16'hFFF0));
        put(r_word(isa_pkg::FN_SLT, 14, 13, 9));
        run_program(1'b0);
    endtask

    task automatic bubble_gaps();
        put(i_word(isa_pkg::OP_ORI, 5, 0, 16'hA5A5));
        put(r_word(isa_pkg::FN_ADDU, 6, 5, 5));
        put(r_word(isa_pkg::FN_XOR, 7, 6, 5));
        put(shift_word(isa_pkg::FN_SRL, 8, 7, 1));
        put(i_word(isa_pkg::OP_SLTIU, 9, 8, 16'h7FFF));
        put(r_word(isa_pkg::FN_NOR, 10, 9, 7));
        run_program(1'b1);
    endtask

    task automatic no_write_cases();
        put(r_word(isa_pkg::FN_ADDU, 0, 1, 2));    // r0 as target
        put(r_word(isa_pkg::FN_OR, 11, 0, 2));     // must not see the r0 result
        put(i_word(isa_pkg::OP_ORI, 0, 0, 16'hFFFF));
        put(32'h8C29_0010);                         // lw r9, not in the kept set
        put(r_word(6'h18, 12, 1, 2));               // mult
        put(r_word(isa_pkg::FN_ADDU, 13, 9, 0));
        run_program(1'b0);
    endtask

    task automatic random_word(output logic [31:0] w);
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        int          sel;
        rd  = 5'($unsigned($random(seed)) % 32'd8);   // few regs, many dependencies
        rs  = 5'($unsigned($random(seed)) % 32'd8);
        rt  = 5'($unsigned($random(seed)) % 32'd8);
        imm = 16'($random(seed));
        sel = int'($unsigned($random(seed)) % 32'd18);
        case (sel)
            0:       w = r_word(isa_pkg::FN_ADDU, rd, rs, rt);
            1:       w = r_word(isa_pkg::FN_SUBU, rd, rs, rt);
            2:       w = r_word(isa_pkg::FN_AND, rd, rs, rt);
            3:       w = r_word(isa_pkg::FN_OR, rd, rs, rt);
            4:       w = r_word(isa_pkg::FN_XOR, rd, rs, rt);
            5:       w = r_word(isa_pkg::FN_NOR, rd, rs, rt);
            6:       w = r_word(isa_pkg::FN_SLT, rd, rs, rt);
            7:       w = r_word(isa_pkg::FN_SLTU, rd, rs, rt);
            8:       w = shift_word(isa_pkg::FN_SLL, rd, rt, imm[4:0]);
            9:       w = shift_word(isa_pkg::FN_SRL, rd, rt, imm[4:0]);
            10:      w = shift_word(isa_pkg::FN_SRA, rd, rt, imm[4:0]);
            11:      w = i_word(isa_pkg::OP_ADDIU, rt, rs, imm);
            12:      w = i_word(isa_pkg::OP_SLTI, rt, rs, imm);
            13:      w = i_word(isa_pkg::OP_SLTIU, rt, rs, imm);
            14:      w = i_word(isa_pkg::OP_ANDI, rt, rs, imm);
            15:      w = i_word(isa_pkg::OP_ORI, rt, rs, imm);
            16:      w = i_word(isa_pkg::OP_XORI, rt, rs, imm);
            default: w = i_word(isa_pkg::OP_LUI, rt, 5'd0, imm);
        endcase
    endtask

    task automatic random_program();
        logic [31:0] w;
        int          k;
        for (k = 0; k < 80; k++) begin
            random_word(w);
            put(w);
        end
        run_program(1'b1);
    endtask

    initial begin
        int i;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_data  = '0;
        mon_on     = 1'b0;
        model_pc   = BOOT_PC;
        prog_end   = 0;
        issued     = 0;
        trace_head = 0;
        for (i = 0; i < 32; i++) begin
            ref_regs[5'(i)] = '0;
        end
        repeat (10) @(posedge aclk);
        #1;
        rst    = 1'b0;
        mon_on = 1'b1;
        reset_values();
        independent_ops();
        dependency_chains();
        bubble_gaps();
        no_write_cases();
        random_program();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* mycpu_top.sv */
// ====================
// 4-stage MIPS32 integer core: fetch, decode, execute, write-back
// plain instruction port, PC advances only on inst_valid
// trace appears 2 cycles after the accepting edge
// ====================
`default_nettype none

module mycpu_top (
    input  logic         aclk,
    input  logic         rst,
    output logic [31:0]  inst_addr,
    input  logic [31:0]  inst_data,
    input  logic         inst_valid,
    output logic [31:0]  debug_wb_pc,
    output logic [31:0]  debug_wb_rf_wdata,
    output logic [3:0]   debug_wb_rf_wen,
    output logic [4:0]   debug_wb_rf_wnum
);

    pipe_pkg::if_id_t   if_id;
    pipe_pkg::id_exe_t  id_exe;
    pipe_pkg::exe_wb_t  exe_out;   // also the forwarding source
    pipe_pkg::rf_wr_t   rf_wr;

    fetch_stage u_fetch (
        .aclk       (aclk),
        .rst        (rst),
        .inst_data  (inst_data),
        .inst_valid (inst_valid),
        .inst_addr  (inst_addr),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .aclk    (aclk),
        .rst     (rst),
        .if_id   (if_id),
        .exe_out (exe_out),
        .rf_wr   (rf_wr),
        .id_exe  (id_exe)
    );

    alu_exe u_exe (
        .id_exe  (id_exe),
        .exe_out (exe_out)
    );

    wb_stage u_wb (
        .aclk              (aclk),
        .rst               (rst),
        .exe_out           (exe_out),
        .rf_wr             (rf_wr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

`default_nettype wire

/* wb_stage.sv */
// ====================
// write-back register and golden-trace outputs
// trace shows every valid instruction, wen is 0 when nothing is written
// reg file is written at the end of the trace cycle
// ====================
`default_nettype none

module wb_stage (
    input  logic                        aclk,
    input  logic                        rst,
    input  pipe_pkg::exe_wb_t           exe_out,
    output pipe_pkg::rf_wr_t            rf_wr,
    output logic [pipe_pkg::XLEN-1:0]   debug_wb_pc,
    output logic [pipe_pkg::XLEN-1:0]   debug_wb_rf_wdata,
    output logic [3:0]                  debug_wb_rf_wen,
    output logic [pipe_pkg::REG_AW-1:0] debug_wb_rf_wnum
);

    pipe_pkg::exe_wb_t wb_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= exe_out.valid;
        end
        wb_q.pc     <= exe_out.pc;
        wb_q.result <= exe_out.result;
        wb_q.dst    <= exe_out.dst;
        wb_q.wr     <= exe_out.wr;
    end

    assign rf_wr.en   = wb_q.valid & wb_q.wr;
    assign rf_wr.num  = wb_q.dst;
    assign rf_wr.data = wb_q.result;

    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_wdata = wb_q.result;
    assign debug_wb_rf_wen   = {4{rf_wr.en}};  // all byte lanes or none
    assign debug_wb_rf_wnum  = wb_q.dst;

endmodule

`default_nettype wire

/* alu_exe.sv */
// ====================
// combinational execute stage, no register
// shift amount comes in operand a, shifted value in b
// lui expects the immediate in b[15:0]
// ====================
`default_nettype none

module alu_exe (
    input  pipe_pkg::id_exe_t  id_exe,
    output pipe_pkg::exe_wb_t  exe_out
);

    logic [pipe_pkg::XLEN-1:0] a, b;
    logic [pipe_pkg::XLEN-1:0] result;
    logic [4:0]                sh;

    assign a  = id_exe.a;
    assign b  = id_exe.b;
    assign sh = a[4:0];

    always_comb begin
        case (id_exe.alu_op)
            isa_pkg::ALU_ADDU: result = a + b;   // no overflow trap
            isa_pkg::ALU_SUBU: result = a - b;
            isa_pkg::ALU_AND:  result = a & b;
            isa_pkg::ALU_OR:   result = a | b;
            isa_pkg::ALU_XOR:  result = a ^ b;
            isa_pkg::ALU_NOR:  result = ~(a | b);
            isa_pkg::ALU_SLT: begin
                result = {{(pipe_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            isa_pkg::ALU_SLTU: begin
                result = {{(pipe_pkg::XLEN-1){1'b0}}, a < b};
            end
            isa_pkg::ALU_SLL:  result = b << sh;
            isa_pkg::ALU_SRL:  result = b >> sh;
            isa_pkg::ALU_SRA:  result = $signed(b) >>> sh;  // keeps sign bit
            isa_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    // control and tags ride along unchanged
    always_comb begin
        exe_out.valid  = id_exe.valid;
        exe_out.pc     = id_exe.pc;
        exe_out.result = result;
        exe_out.dst    = id_exe.dst;
        exe_out.wr     = id_exe.wr;
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
// ====================
// field decode, operand select and decode-to-execute register
// forwards only from execute, write-back goes through the reg file
// unsupported encodings flow on with wr low
// ====================
`default_nettype none

module decode_stage (
    input  logic               aclk,
    input  logic               rst,
    input  pipe_pkg::if_id_t   if_id,
    input  pipe_pkg::exe_wb_t  exe_out,
    input  pipe_pkg::rf_wr_t   rf_wr,
    output pipe_pkg::id_exe_t  id_exe
);

    isa_pkg::instr_u                ins;
    isa_pkg::alu_op_e               alu_op;
    logic                           supported;
    logic                           use_imm;
    logic                           is_shift;
    logic [pipe_pkg::REG_AW-1:0]    dst;
    logic [pipe_pkg::XLEN-1:0]      imm_ext;
    logic [pipe_pkg::XLEN-1:0]      rs_rf, rt_rf;
    logic [pipe_pkg::XLEN-1:0]      rs_val, rt_val;

    // exe result wins over the reg file read
    function automatic logic [pipe_pkg::XLEN-1:0] fwd(
        input pipe_pkg::exe_wb_t           ex,
        input logic [pipe_pkg::REG_AW-1:0] num,
        input logic [pipe_pkg::XLEN-1:0]   rf_val
    );
        return (ex.valid && ex.wr && ex.dst == num) ? ex.result : rf_val;
    endfunction

    assign ins = if_id.instr;

    reg_file u_reg_file (
        .aclk    (aclk),
        .rs_num  (ins.r.rs),
        .rt_num  (ins.r.rt),
        .rf_wr   (rf_wr),
        .rs_data (rs_rf),
        .rt_data (rt_rf)
    );

    assign rs_val = fwd(exe_out, ins.r.rs, rs_rf);
    assign rt_val = fwd(exe_out, ins.r.rt, rt_rf);

    always_comb begin
        alu_op    = isa_pkg::ALU_ADDU;
        supported = 1'b1;
        use_imm   = 1'b1;
        is_shift  = 1'b0;
        dst       = ins.i.rt;                                   // I-type target
        imm_ext   = {{16{ins.i.imm16[15]}}, ins.i.imm16};       // sign-extend
        case (ins.r.opcode)
            isa_pkg::OP_SPECIAL: begin
                use_imm = 1'b0;
                dst     = ins.r.rd;
                case (ins.r.funct)
                    isa_pkg::FN_SLL:  begin alu_op = isa_pkg::ALU_SLL; is_shift = 1'b1; end
                    isa_pkg::FN_SRL:  begin alu_op = isa_pkg::ALU_SRL; is_shift = 1'b1; end
                    isa_pkg::FN_SRA:  begin alu_op = isa_pkg::ALU_SRA; is_shift = 1'b1; end
                    isa_pkg::FN_ADDU: alu_op = isa_pkg::ALU_ADDU;
                    isa_pkg::FN_SUBU: alu_op = isa_pkg::ALU_SUBU;
                    isa_pkg::FN_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::FN_SLTU: alu_op = isa_pkg::ALU_SLTU;
                    default:          supported = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: alu_op = isa_pkg::ALU_ADDU;
            isa_pkg::OP_SLTI:  alu_op = isa_pkg::ALU_SLT;
            isa_pkg::OP_SLTIU: alu_op = isa_pkg::ALU_SLTU;
            // logical immediates are zero-extended
            isa_pkg::OP_ANDI:  begin alu_op = isa_pkg::ALU_AND; imm_ext[31:16] = '0; end
            isa_pkg::OP_ORI:   begin alu_op = isa_pkg::ALU_OR;  imm_ext[31:16] = '0; end
            isa_pkg::OP_XORI:  begin alu_op = isa_pkg::ALU_XOR; imm_ext[31:16] = '0; end
            isa_pkg::OP_LUI:   begin alu_op = isa_pkg::ALU_LUI; imm_ext[31:16] = '0; end
            default:           supported = 1'b0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            id_exe.valid <= 1'b0;
        end else begin
            id_exe.valid <= if_id.valid;
        end
        id_exe.pc     <= if_id.pc;
        id_exe.alu_op <= alu_op;
        id_exe.a      <= is_shift ? {{(pipe_pkg::XLEN-5){1'b0}}, ins.r.shamt} : rs_val;
        id_exe.b      <= use_imm ? imm_ext : rt_val;
        id_exe.dst    <= dst;
        id_exe.wr     <= supported && (dst != '0);  // r0 never written
    end

endmodule

`default_nettype wire

/* reg_file.sv */
// ====================
// 32 x 32 general registers, two read ports
// r0 always reads zero
// same-cycle write is visible on the read ports
// ====================
`default_nettype none

module reg_file (
    input  logic                        aclk,
    input  logic [pipe_pkg::REG_AW-1:0] rs_num,
    input  logic [pipe_pkg::REG_AW-1:0] rt_num,
    input  pipe_pkg::rf_wr_t            rf_wr,
    output logic [pipe_pkg::XLEN-1:0]   rs_data,
    output logic [pipe_pkg::XLEN-1:0]   rt_data
);

    logic [pipe_pkg::XLEN-1:0] regs [pipe_pkg::NREGS];

    always_ff @(posedge aclk) begin
        if (rf_wr.en && rf_wr.num != '0) begin
            regs[rf_wr.num] <= rf_wr.data;
        end
    end

    // write-through keeps distance-2 dependencies stall free
    assign rs_data = (rs_num == '0) ? '0 :
                     (rf_wr.en && rf_wr.num == rs_num) ? rf_wr.data : regs[rs_num];
    assign rt_data = (rt_num == '0) ? '0 :
                     (rf_wr.en && rf_wr.num == rt_num) ? rf_wr.data : regs[rt_num];

endmodule

`default_nettype wire

/* fetch_stage.sv */
// ====================
// PC and fetch-to-decode register
// inst_data must hold the word at inst_addr while inst_valid is high
// no back-pressure, a missing word becomes a bubble
// ====================
`default_nettype none

module fetch_stage (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic [pipe_pkg::XLEN-1:0]  inst_data,
    input  logic                       inst_valid,
    output logic [pipe_pkg::XLEN-1:0]  inst_addr,
    output pipe_pkg::if_id_t           if_id
);

    logic [pipe_pkg::XLEN-1:0] pc;

    always_ff @(posedge aclk) begin
        if (rst) begin
            pc          <= isa_pkg::RESET_PC;
            if_id.valid <= 1'b0;
        end else begin
            if_id.valid <= inst_valid;  // low means bubble
            if (inst_valid) begin
                pc <= pc + pipe_pkg::XLEN'(4);
            end
        end
        // payload captured on accept
        if (inst_valid) begin
            if_id.pc    <= pc;
            if_id.instr <= inst_data;
        end
    end

    assign inst_addr = pc;

endmodule

`default_nettype wire

/* pipe_pkg.sv */
// ====================
// stage-to-stage bundles of the 4-stage pipeline
// payload fields are only meaningful while valid is high
// depends on isa_pkg for the ALU op type
// ====================
`default_nettype none

package pipe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int NREGS  = 32;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        isa_pkg::alu_op_e  alu_op;
        logic [XLEN-1:0]   a;      // shamt for shifts
        logic [XLEN-1:0]   b;      // rt value or extended immediate
        logic [REG_AW-1:0] dst;
        logic              wr;
    } id_exe_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   result;
        logic [REG_AW-1:0] dst;
        logic              wr;
    } exe_wb_t;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] num;
        logic [XLEN-1:0]   data;
    } rf_wr_t;

endpackage

`default_nettype wire

/* isa_pkg.sv */
// ====================
// MIPS32 encodings for the integer ALU subset only
// no branch, load/store, mul/div or CP0 codes are defined
// boot address follows the usual MIPS reset vector
// ====================
`default_nettype none

package isa_pkg;

    localparam logic [31:0] RESET_PC = 32'hBFC0_0000;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // funct field under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    // same word, two field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire
